/* rtl/conv_pkg.sv */
`default_nettype none

package conv_pkg;

    // image and kernel geometry
    localparam int img_w = 28;
    localparam int img_h = 28;
    localparam int kern = 3;
    localparam int taps = kern * kern;
    localparam int out_w = img_w - kern + 1;
    localparam int out_h = img_h - kern + 1;
    localparam int out_count = out_w * out_h;

    // M0 layout, parameters sit right after the image
    localparam int weight_base = img_w * img_h;
    localparam int bias_word = weight_base + taps;
    localparam int param_words = taps + 1;

    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int frac_bits = 16;

    // cycles from the last tap request to its M1 write
    localparam int read_to_write = 5;

    // read sequencer phases
    localparam logic [1:0] ph_idle = 2'd0;
    localparam logic [1:0] ph_param = 2'd1;
    localparam logic [1:0] ph_window = 2'd2;

    typedef logic signed [data_w-1:0] fix_word;

    // Q32.32 product, written as a whole and read back as guard/value/fraction
    typedef union packed {
        logic signed [2*data_w-1:0] raw;
        struct packed {
            logic [data_w-frac_bits-1:0] guard;
            fix_word value;
            logic [frac_bits-1:0] frac;
        } field;
    } fix_prod;

endpackage

`default_nettype wire

/* rtl/read_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module read_sequencer import conv_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              start,
    output logic [addr_w-1:0]      m0_addr,
    output logic                   m0_rd_req,
    output logic                   data_valid,
    output logic                   data_is_param,
    output logic [3:0]             data_index,
    output logic                   busy
);

    logic [1:0] phase;
    logic [3:0] idx;
    logic [1:0] tap_r;
    logic [1:0] tap_c;
    logic [4:0] row;
    logic [4:0] col;
    logic [2:0] drain;

    assign m0_rd_req = (phase != ph_idle);

    // byte address, word index times four
    always_comb begin
        if (phase == ph_param) begin
            m0_addr = addr_w'((weight_base + int'(idx)) * 4);
        end else begin
            m0_addr = addr_w'(((int'(row) + int'(tap_r)) * img_w
                               + int'(col) + int'(tap_c)) * 4);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            phase <= ph_idle;
            idx <= '0;
            tap_r <= '0;
            tap_c <= '0;
            row <= '0;
            col <= '0;
            drain <= '0;
            busy <= 1'b0;
            data_valid <= 1'b0;
            data_is_param <= 1'b0;
            data_index <= '0;
        end else begin
            // tag follows the request by one cycle, same as the memory
            data_valid <= m0_rd_req;
            data_is_param <= (phase == ph_param);
            data_index <= idx;

            case (phase)
                ph_idle: begin
                    if (start && !busy) begin
                        phase <= ph_param;
                        idx <= '0;
                        busy <= 1'b1;
                    end
                end
                ph_param: begin
                    if (idx == 4'(param_words - 1)) begin
                        phase <= ph_window;
                        idx <= '0;
                        tap_r <= '0;
                        tap_c <= '0;
                        row <= '0;
                        col <= '0;
                    end else begin
                        idx <= idx + 4'd1;
                    end
                end
                ph_window: begin
                    if (tap_c == 2'(kern - 1)) begin
                        tap_c <= '0;
                        if (tap_r == 2'(kern - 1)) begin
                            tap_r <= '0;
                        end else begin
                            tap_r <= tap_r + 2'd1;
                        end
                    end else begin
                        tap_c <= tap_c + 2'd1;
                    end

                    if (idx == 4'(taps - 1)) begin
                        idx <= '0;
                        // window done, step the output position
                        if (col == 5'(out_w - 1)) begin
                            col <= '0;
                            if (row == 5'(out_h - 1)) begin
                                phase <= ph_idle;
                                drain <= 3'(read_to_write);
                            end else begin
                                row <= row + 5'd1;
                            end
                        end else begin
                            col <= col + 5'd1;
                        end
                    end else begin
                        idx <= idx + 4'd1;
                    end
                end
                default: begin
                    phase <= ph_idle;
                end
            endcase

            // busy drops once the last result has been written
            if (drain != 3'd0) begin
                drain <= drain - 3'd1;
                if (drain == 3'd1) begin
                    busy <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/coeff_store.sv */
`timescale 1ns/1ps
`default_nettype none

module coeff_store import conv_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              data_valid,
    input  wire logic              data_is_param,
    input  wire logic [3:0]        data_index,
    input  wire logic [data_w-1:0] m0_rd_data,
    output fix_word                weights [taps],
    output fix_word                bias
);

    logic param_ret;

    // nothing is captured while reset is held
    assign param_ret = rst && data_valid && data_is_param;

    always_ff @(posedge clk) begin
        if (param_ret) begin
            if (data_index == 4'(bias_word - weight_base)) begin
                bias <= m0_rd_data;
            end else begin
                for (int k = 0; k < taps; k++) begin
                    if (data_index == 4'(k)) begin
                        weights[k] <= m0_rd_data;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/tap_mac.sv */
`timescale 1ns/1ps
`default_nettype none

module tap_mac import conv_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              data_valid,
    input  wire logic              data_is_param,
    input  wire logic [3:0]        data_index,
    input  wire logic [data_w-1:0] m0_rd_data,
    input  wire fix_word           weights [taps],
    input  wire fix_word           bias,
    output logic                   sum_valid,
    output fix_word                sum
);

    fix_word shift_q [taps-1];
    fix_word window [taps];
    logic tap_ret;
    logic last_tap;

    fix_prod prod_q [taps];
    logic prod_v;
    fix_word rnd_q [taps];
    logic rnd_v;
    logic signed [2*data_w-1:0] acc;

    assign tap_ret = data_valid && !data_is_param;
    assign last_tap = tap_ret && (data_index == 4'(taps - 1));

    // eight held taps plus the word arriving now
    always_comb begin
        for (int k = 0; k < taps - 1; k++) begin
            window[k] = shift_q[k];
        end
        window[taps-1] = m0_rd_data;
    end

    always_ff @(posedge clk) begin
        if (tap_ret) begin
            for (int k = 0; k < taps - 2; k++) begin
                shift_q[k] <= shift_q[k+1];
            end
            shift_q[taps-2] <= m0_rd_data;
        end
    end

    // multiply
    always_ff @(posedge clk) begin
        if (last_tap) begin
            for (int k = 0; k < taps; k++) begin
                prod_q[k].raw <= 64'(window[k]) * 64'(weights[k]);
            end
        end
    end

    // round half up on the top fraction bit
    always_ff @(posedge clk) begin
        if (prod_v) begin
            for (int k = 0; k < taps; k++) begin
                rnd_q[k] <= prod_q[k].field.value
                            + 32'(prod_q[k].field.frac[frac_bits-1]);
            end
        end
    end

    always_comb begin
        acc = 64'(bias);
        for (int k = 0; k < taps; k++) begin
            acc = acc + 64'(rnd_q[k]);
        end
    end

    always_ff @(posedge clk) begin
        if (rnd_v) begin
            sum <= acc[data_w-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            prod_v <= 1'b0;
            rnd_v <= 1'b0;
            sum_valid <= 1'b0;
        end else begin
            prod_v <= last_tap;
            rnd_v <= prod_v;
            sum_valid <= rnd_v;
        end
    end

endmodule

`default_nettype wire

/* rtl/result_writer.sv */
`timescale 1ns/1ps
`default_nettype none

module result_writer import conv_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              busy,
    input  wire logic              sum_valid,
    input  wire fix_word           sum,
    output logic [addr_w-1:0]      m1_addr,
    output logic                   m1_wr_req,
    output logic [data_w-1:0]      m1_wr_data,
    output logic                   finish
);

    logic [9:0] out_idx;
    logic busy_q;

    always_ff @(posedge clk) begin
        if (!rst) begin
            out_idx <= '0;
            busy_q <= 1'b0;
            m1_wr_req <= 1'b0;
            finish <= 1'b0;
        end else begin
            busy_q <= busy;
            m1_wr_req <= sum_valid;
            if (busy && !busy_q) begin
                // new run
                finish <= 1'b0;
                out_idx <= '0;
            end else begin
                if (sum_valid) begin
                    out_idx <= out_idx + 10'd1;
                end
                if (m1_wr_req && m1_addr == addr_w'((out_count - 1) * 4)) begin
                    finish <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sum_valid) begin
            m1_addr <= addr_w'({out_idx, 2'b00});
            m1_wr_data <= sum;
        end
    end

endmodule

`default_nettype wire

/* rtl/conv_top.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_top import conv_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              start,
    output logic [addr_w-1:0]      m0_addr,
    output logic                   m0_rd_req,
    input  wire logic [data_w-1:0] m0_rd_data,
    output logic [addr_w-1:0]      m1_addr,
    output logic                   m1_wr_req,
    output logic [data_w-1:0]      m1_wr_data,
    output logic                   finish
);

    logic data_valid;
    logic data_is_param;
    logic [3:0] data_index;
    logic busy;
    fix_word weights [taps];
    fix_word bias;
    logic sum_valid;
    fix_word sum;

    read_sequencer u_read_sequencer (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .m0_addr       (m0_addr),
        .m0_rd_req     (m0_rd_req),
        .data_valid    (data_valid),
        .data_is_param (data_is_param),
        .data_index    (data_index),
        .busy          (busy)
    );

    coeff_store u_coeff_store (
        .clk           (clk),
        .rst           (rst),
        .data_valid    (data_valid),
        .data_is_param (data_is_param),
        .data_index    (data_index),
        .m0_rd_data    (m0_rd_data),
        .weights       (weights),
        .bias          (bias)
    );

    tap_mac u_tap_mac (
        .clk           (clk),
        .rst           (rst),
        .data_valid    (data_valid),
        .data_is_param (data_is_param),
        .data_index    (data_index),
        .m0_rd_data    (m0_rd_data),
        .weights       (weights),
        .bias          (bias),
        .sum_valid     (sum_valid),
        .sum           (sum)
    );

    result_writer u_result_writer (
        .clk           (clk),
        .rst           (rst),
        .busy          (busy),
        .sum_valid     (sum_valid),
        .sum           (sum),
        .m1_addr       (m1_addr),
        .m1_wr_req     (m1_wr_req),
        .m1_wr_data    (m1_wr_data),
        .finish        (finish)
    );

endmodule

`default_nettype wire

/* verif/conv_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_properties import conv_pkg::*; (
    input wire logic              clk,
    input wire logic              rst,
    input wire logic              start,
    input wire logic [addr_w-1:0] m0_addr,
    input wire logic              m0_rd_req,
    input wire logic              m1_wr_req,
    input wire logic              finish
);

    // no writes once the job has finished
    no_write_when_done: assert property (
        @(posedge clk) disable iff (!rst) finish |-> !m1_wr_req
    ) else $error("m1_wr_req high while finish is high");

    // finish only drops in the wake of a start
    finish_held: assert property (
        @(posedge clk) disable iff (!rst) finish && !start |=> finish || $past(start, 2)
    ) else $error("finish dropped without start");

    read_in_range: assert property (
        @(posedge clk) disable iff (!rst) m0_rd_req |-> m0_addr <= addr_w'(bias_word * 4)
    ) else $error("m0_addr beyond the bias word");

endmodule

bind conv_top conv_properties u_conv_properties (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .m0_addr   (m0_addr),
    .m0_rd_req (m0_rd_req),
    .m1_wr_req (m1_wr_req),
    .finish    (finish)
);

`default_nettype wire

/* verif/tb_conv.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_conv;

    logic clk;
    logic rst;
    logic start;
    logic [31:0] m0_addr;
    logic m0_rd_req;
    logic [31:0] m0_rd_data;
    logic [31:0] m1_addr;
    logic m1_wr_req;
    logic [31:0] m1_wr_data;
    logic finish;

    logic [31:0] mem [0:793];
    int cycle;
    logic finish_d;
    int finish_rise;
    int unsigned rd_addr_q [$];
    int rd_cycle_q [$];
    logic [31:0] wr_addr_q [$];
    logic [31:0] wr_data_q [$];
    int wr_cycle_q [$];

    conv_top dut (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .m0_addr    (m0_addr),
        .m0_rd_req  (m0_rd_req),
        .m0_rd_data (m0_rd_data),
        .m1_addr    (m1_addr),
        .m1_wr_req  (m1_wr_req),
        .m1_wr_data (m1_wr_data),
        .finish     (finish)
    );

    always #10 clk = ~clk;

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("Error: time %0t %s got %h expected %h", $time, name, got, exp);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    task automatic fail_with(input string what);
        $display("%s", what);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    // M0 model, one cycle read latency
    always @(posedge clk) begin
        logic [31:0] word;
        if (m0_rd_req) begin
            if ((m0_addr >> 2) > 793) begin
                fail_with("read request outside the M0 image and parameter area");
            end
            word = mem[m0_addr >> 2];
            rd_addr_q.push_back(m0_addr);
            rd_cycle_q.push_back(cycle);
            m0_rd_data <= #2 word;
        end
    end

    // M1 model, cycle counter and finish edge
    always @(posedge clk) begin
        cycle <= cycle + 1;
        finish_d <= finish;
        if (finish && !finish_d) begin
            finish_rise <= cycle;
        end
        if (m1_wr_req) begin
            wr_addr_q.push_back(m1_addr);
            wr_data_q.push_back(m1_wr_data);
            wr_cycle_q.push_back(cycle);
        end
    end

    function automatic logic [31:0] round_term(input logic [31:0] pix, input logic [31:0] w);
        logic signed [63:0] p;
        p = 64'($signed(pix)) * 64'($signed(w));
        return p[47:16] + 32'(p[15]);
    endfunction

    function automatic logic [31:0] ref_pixel(input int r, input int c);
        logic signed [63:0] acc;
        acc = 64'($signed(mem[793]));
        for (int t = 0; t < 9; t++) begin
            acc = acc + 64'($signed(round_term(mem[(r + t / 3) * 28 + c + t % 3], mem[784 + t])));
        end
        return acc[31:0];
    endfunction

    task automatic run_job();
        int n;
        rd_addr_q.delete();
        rd_cycle_q.delete();
        wr_addr_q.delete();
        wr_data_q.delete();
        wr_cycle_q.delete();
        finish_rise = -1;
        @(posedge clk);
        #2 start = 1'b1;
        @(posedge clk);
        #2 start = 1'b0;
        n = 0;
        while (finish) begin
            @(posedge clk);
            #2;
            n++;
            if (n > 10) fail_with("finish did not clear after start");
        end
        n = 0;
        while (!finish) begin
            @(posedge clk);
            #2;
            n++;
            if (n > 10000) fail_with("timeout waiting for finish");
        end
    endtask

    task automatic check_reads();
        int k;
        check("read count", rd_addr_q.size(), 10 + 676 * 9);
        for (int i = 0; i < 10; i++) begin
            check("m0_addr param", rd_addr_q[i], (784 + i) * 4);
        end
        for (int p = 0; p < 676; p++) begin
            for (int t = 0; t < 9; t++) begin
                k = 10 + p * 9 + t;
                check("m0_addr window", rd_addr_q[k],
                      ((p / 26 + t / 3) * 28 + p % 26 + t % 3) * 4);
            end
        end
        for (int i = 1; i < rd_cycle_q.size(); i++) begin
            check("read cycle gap", rd_cycle_q[i] - rd_cycle_q[i-1], 1);
        end
    endtask

    task automatic check_writes();
        check("write count", wr_addr_q.size(), 676);
        for (int p = 0; p < 676; p++) begin
            check("m1_addr", wr_addr_q[p], p * 4);
            check("m1_wr_data", wr_data_q[p], ref_pixel(p / 26, p % 26));
            check("write latency", wr_cycle_q[p] - rd_cycle_q[10 + p * 9 + 8], 5);
            if (p > 0) check("write spacing", wr_cycle_q[p] - wr_cycle_q[p-1], 9);
        end
        repeat (20) begin
            @(posedge clk);
            #2;
            check("finish", finish, 1);
        end
        // rise is recorded on the edge after finish goes high
        check("finish rise", finish_rise, wr_cycle_q[675] + 1);
        check("writes after finish", wr_addr_q.size(), 676);
    endtask

    task automatic fill_random();
        for (int i = 0; i < 794; i++) begin
            mem[i] = $urandom;
        end
    endtask

    task automatic test_reset_idle();
        repeat (5) begin
            @(posedge clk);
            #2;
            check("m0_rd_req", m0_rd_req, 0);
            check("m1_wr_req", m1_wr_req, 0);
            check("finish", finish, 0);
        end
    endtask

    task automatic test_random_image();
        fill_random();
        run_job();
        check_reads();
        check_writes();
    endtask

    task automatic test_rounding();
        logic [31:0] pick [4];
        logic [31:0] wts [9];
        // hand values for the rounding rule
        check("round half", round_term(32'h1, 32'h8000), 32'h1);
        check("round one", round_term(32'h10000, 32'h8000), 32'h8000);
        check("round up", round_term(32'h1, 32'h18000), 32'h2);
        check("round below", round_term(32'h1, 32'h7fff), 32'h0);
        check("round neg", round_term(32'hffff0000, 32'h20000), 32'hfffe0000);
        pick = '{32'h1, 32'hffffffff, 32'h8000, 32'hffff7fff};
        wts = '{32'h8000, 32'h7fff, 32'hffff8000, 32'h10000, 32'h18000,
                32'hfffe0000, 32'h4000, 32'hffffffff, 32'h1};
        for (int i = 0; i < 784; i++) begin
            mem[i] = pick[i % 4] + (i << 16);
        end
        for (int t = 0; t < 9; t++) begin
            mem[784 + t] = wts[t];
        end
        mem[793] = 32'hffff0000;
        run_job();
        check_writes();
    endtask

    task automatic test_second_run();
        fill_random();
        run_job();
        check_reads();
        check_writes();
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b0;
        start = 1'b0;
        m0_rd_data = '0;
        cycle = 0;
        finish_d = 1'b0;
        finish_rise = -1;
        void'($urandom(32'hd8f1));
        for (int i = 0; i < 794; i++) begin
            mem[i] = '0;
        end
        repeat (16) @(posedge clk);
        #2 rst = 1'b1;
        test_reset_idle();
        test_random_image();
        test_rounding();
        test_second_run();
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
rtl/conv_pkg.sv
rtl/read_sequencer.sv
rtl/coeff_store.sv
rtl/tap_mac.sv
rtl/result_writer.sv
rtl/conv_top.sv
verif/conv_properties.sv
verif/tb_conv.sv

/* Makefile */
TOP = tb_conv

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f src.f

obj_dir/V$(TOP): src.f rtl/*.sv verif/*.sv
	verilator --binary --timing --assert --top-module $(TOP) -f src.f

sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf obj_dir
